// ==== source/la32_cfg.svh ====
`ifndef LA32_CFG_SVH
`define LA32_CFG_SVH

// datapath and register file
`define LA32_XLEN      32
`define LA32_NREG      32
`define LA32_RADDR_W   5
`define LA32_RF_RST    {`LA32_XLEN{1'b0}}

// ##########################################################
// 3R and shift-immediate forms, inst[31:15]
`define LA32_OP_ADDW    17'h00020
`define LA32_OP_SUBW    17'h00022
`define LA32_OP_SLT     17'h00024
`define LA32_OP_SLTU    17'h00025
`define LA32_OP_NOR     17'h00028
`define LA32_OP_AND     17'h00029
`define LA32_OP_OR      17'h0002a
`define LA32_OP_XOR     17'h0002b
`define LA32_OP_SLLW    17'h0002e
`define LA32_OP_SRLW    17'h0002f
`define LA32_OP_SRAW    17'h00030
`define LA32_OP_BREAK   17'h00054
`define LA32_OP_SYSCALL 17'h00056
`define LA32_OP_SLLIW   17'h00081
`define LA32_OP_SRLIW   17'h00089
`define LA32_OP_SRAIW   17'h00091

// 2RI12 forms, inst[31:22]
`define LA32_OP_SLTI    10'h008
`define LA32_OP_SLTUI   10'h009
`define LA32_OP_ADDIW   10'h00a
`define LA32_OP_ANDI    10'h00d
`define LA32_OP_ORI     10'h00e
`define LA32_OP_XORI    10'h00f

// 1RI20 forms, inst[31:25]
`define LA32_OP_LU12I   7'h0a

`endif

// ==== source/la32_pkg.sv ====
`include "la32_cfg.svh"

package la32_pkg;

  typedef logic [`LA32_XLEN-1:0] word_t;
  typedef logic [`LA32_RADDR_W-1:0] reg_addr_t;

  typedef enum logic [4:0] {
    op_nop,
    op_add,
    op_sub,
    op_slt,
    op_sltu,
    op_nor,
    op_and,
    op_or,
    op_xor,
    op_sll,
    op_srl,
    op_sra,
    op_lui
  } alu_op_e;

  typedef enum logic [1:0] {
    exc_none,
    exc_ine,
    exc_brk,
    exc_sys
  } exc_cause_e;

  // ##########################################################
  // instruction formats, all 32 bits wide

  // also carries the 5-bit shift amount in the rk slot
  typedef struct packed {
    logic [16:0] opcode;
    reg_addr_t   rk;
    reg_addr_t   rj;
    reg_addr_t   rd;
  } fmt_3r_t;

  typedef struct packed {
    logic [9:0]  opcode;
    logic [11:0] imm12;
    reg_addr_t   rj;
    reg_addr_t   rd;
  } fmt_2ri12_t;

  typedef struct packed {
    logic [6:0]  opcode;
    logic [19:0] imm20;
    reg_addr_t   rd;
  } fmt_1ri20_t;

  typedef union packed {
    fmt_3r_t    r3;
    fmt_2ri12_t ri12;
    fmt_1ri20_t ri20;
  } inst_word_u;

endpackage

// ==== source/la32_decode.sv ====
`timescale 1ns/1ns
`include "la32_cfg.svh"

module la32_decode (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   inst_valid,
  input  la32_pkg::word_t        inst,
  output logic                   dec_valid,
  output la32_pkg::alu_op_e      dec_op,
  output la32_pkg::reg_addr_t    dec_rj,
  output la32_pkg::reg_addr_t    dec_rk,
  output la32_pkg::reg_addr_t    dec_rd,
  output logic                   dec_use_imm,
  output la32_pkg::word_t        dec_imm,
  output logic                   dec_we,
  output logic                   dec_exc,
  output la32_pkg::exc_cause_e   dec_cause
);

  import la32_pkg::*;

  inst_word_u iw;
  alu_op_e    op_c;
  logic       use_imm_c;
  word_t      imm_c;
  reg_addr_t  rj_c;
  exc_cause_e cause_c;
  logic       hit_c;
  logic       exc_c;
  logic       we_c;
  word_t      simm12;
  word_t      uimm12;
  word_t      shamt5;

  assign iw = inst;

  assign simm12 = {{20{iw.ri12.imm12[11]}}, iw.ri12.imm12};
  assign uimm12 = {20'b0, iw.ri12.imm12};
  assign shamt5 = {27'b0, iw.r3.rk};

  // ##########################################################
  // widest opcode field matched first
  always_comb begin
    op_c      = op_nop;
    use_imm_c = 1'b0;
    imm_c     = '0;
    rj_c      = iw.r3.rj;
    cause_c   = exc_none;
    hit_c     = 1'b1;
    case (iw.r3.opcode)
      `LA32_OP_ADDW:    op_c = op_add;
      `LA32_OP_SUBW:    op_c = op_sub;
      `LA32_OP_SLT:     op_c = op_slt;
      `LA32_OP_SLTU:    op_c = op_sltu;
      `LA32_OP_NOR:     op_c = op_nor;
      `LA32_OP_AND:     op_c = op_and;
      `LA32_OP_OR:      op_c = op_or;
      `LA32_OP_XOR:     op_c = op_xor;
      `LA32_OP_SLLW:    op_c = op_sll;
      `LA32_OP_SRLW:    op_c = op_srl;
      `LA32_OP_SRAW:    op_c = op_sra;
      `LA32_OP_BREAK:   cause_c = exc_brk;
      `LA32_OP_SYSCALL: cause_c = exc_sys;
      `LA32_OP_SLLIW: begin
        op_c      = op_sll;
        use_imm_c = 1'b1;
        imm_c     = shamt5;
      end
      `LA32_OP_SRLIW: begin
        op_c      = op_srl;
        use_imm_c = 1'b1;
        imm_c     = shamt5;
      end
      `LA32_OP_SRAIW: begin
        op_c      = op_sra;
        use_imm_c = 1'b1;
        imm_c     = shamt5;
      end
      default: begin
        // every remaining form takes an immediate
        use_imm_c = 1'b1;
        case (iw.ri12.opcode)
          `LA32_OP_SLTI: begin
            op_c  = op_slt;
            imm_c = simm12;
          end
          `LA32_OP_SLTUI: begin
            op_c  = op_sltu;
            imm_c = simm12;
          end
          `LA32_OP_ADDIW: begin
            op_c  = op_add;
            imm_c = simm12;
          end
          `LA32_OP_ANDI: begin
            op_c  = op_and;
            imm_c = uimm12;
          end
          `LA32_OP_ORI: begin
            op_c  = op_or;
            imm_c = uimm12;
          end
          `LA32_OP_XORI: begin
            op_c  = op_xor;
            imm_c = uimm12;
          end
          default: begin
            case (iw.ri20.opcode)
              `LA32_OP_LU12I: begin
                op_c  = op_lui;
                imm_c = {iw.ri20.imm20, 12'b0};
                rj_c  = '0;
              end
              default: hit_c = 1'b0;
            endcase
          end
        endcase
      end
    endcase

    // zero word falls through as a plain nop
    if (!hit_c && inst != '0) begin
      cause_c = exc_ine;
    end
  end

  assign exc_c = (cause_c != exc_none);
  assign we_c  = hit_c && !exc_c && (iw.r3.rd != '0);

  // ##########################################################
  // decode register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      dec_valid <= 1'b0;
      dec_we    <= 1'b0;
      dec_exc   <= 1'b0;
    end else begin
      dec_valid <= inst_valid;
      dec_we    <= inst_valid && we_c;
      dec_exc   <= inst_valid && exc_c;
    end
  end

  always_ff @(posedge clk) begin
    if (inst_valid) begin
      dec_op      <= op_c;
      dec_rj      <= rj_c;
      dec_rk      <= iw.r3.rk;
      dec_rd      <= iw.r3.rd;
      dec_use_imm <= use_imm_c;
      dec_imm     <= imm_c;
      dec_cause   <= cause_c;
    end
  end

endmodule

// ==== source/la32_execute.sv ====
`timescale 1ns/1ns

module la32_execute (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   dec_valid,
  input  la32_pkg::alu_op_e      dec_op,
  input  la32_pkg::reg_addr_t    dec_rj,
  input  la32_pkg::reg_addr_t    dec_rk,
  input  la32_pkg::reg_addr_t    dec_rd,
  input  logic                   dec_use_imm,
  input  la32_pkg::word_t        dec_imm,
  input  logic                   dec_we,
  input  logic                   dec_exc,
  input  la32_pkg::exc_cause_e   dec_cause,
  output la32_pkg::reg_addr_t    rf_rj_addr,
  output la32_pkg::reg_addr_t    rf_rk_addr,
  input  la32_pkg::word_t        rf_rj_data,
  input  la32_pkg::word_t        rf_rk_data,
  output logic                   ex_valid,
  output logic                   ex_we,
  output la32_pkg::reg_addr_t    ex_rd,
  output la32_pkg::word_t        ex_data,
  output logic                   ex_exc,
  output la32_pkg::exc_cause_e   ex_cause
);

  import la32_pkg::*;

  word_t      opnd_a;
  word_t      opnd_rk;
  word_t      opnd_b;
  logic [4:0] shamt;
  word_t      alu_c;

  assign rf_rj_addr = dec_rj;
  assign rf_rk_addr = dec_rk;

  // bypass from our own result register; ex_we is never set for r0
  assign opnd_a  = (ex_we && ex_rd == dec_rj) ? ex_data : rf_rj_data;
  assign opnd_rk = (ex_we && ex_rd == dec_rk) ? ex_data : rf_rk_data;

  assign opnd_b = dec_use_imm ? dec_imm : opnd_rk;
  assign shamt  = opnd_b[4:0];

  // ##########################################################
  // ALU
  always_comb begin
    case (dec_op)
      op_add:  alu_c = opnd_a + opnd_b;
      op_sub:  alu_c = opnd_a - opnd_b;
      op_slt:  alu_c = word_t'($signed(opnd_a) < $signed(opnd_b));
      op_sltu: alu_c = word_t'(opnd_a < opnd_b);
      op_nor:  alu_c = ~(opnd_a | opnd_b);
      op_and:  alu_c = opnd_a & opnd_b;
      op_or:   alu_c = opnd_a | opnd_b;
      op_xor:  alu_c = opnd_a ^ opnd_b;
      op_sll:  alu_c = opnd_a << shamt;
      op_srl:  alu_c = opnd_a >> shamt;
      op_sra:  alu_c = word_t'($signed(opnd_a) >>> shamt);
      op_lui:  alu_c = opnd_b;
      default: alu_c = '0;
    endcase
  end

  // ##########################################################
  // result register
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      ex_valid <= 1'b0;
      ex_we    <= 1'b0;
      ex_exc   <= 1'b0;
    end else begin
      ex_valid <= dec_valid;
      ex_we    <= dec_valid && dec_we;
      ex_exc   <= dec_valid && dec_exc;
    end
  end

  always_ff @(posedge clk) begin
    ex_rd    <= dec_rd;
    ex_data  <= alu_c;
    ex_cause <= dec_cause;
  end

  a_fwd_no_r0: assert property (@(posedge clk) disable iff (!rst_n) ex_we |-> ex_rd != '0)
    else $error("result register would forward a write to r0");

  a_we_no_exc: assert property (@(posedge clk) disable iff (!rst_n) !(ex_we && ex_exc))
    else $error("write enable set on an excepting instruction");

endmodule

// ==== source/la32_result.sv ====
`timescale 1ns/1ns
`include "la32_cfg.svh"

module la32_result (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   ex_valid,
  input  logic                   ex_we,
  input  la32_pkg::reg_addr_t    ex_rd,
  input  la32_pkg::word_t        ex_data,
  input  logic                   ex_exc,
  input  la32_pkg::exc_cause_e   ex_cause,
  input  la32_pkg::reg_addr_t    rf_rj_addr,
  input  la32_pkg::reg_addr_t    rf_rk_addr,
  output la32_pkg::word_t        rf_rj_data,
  output la32_pkg::word_t        rf_rk_data,
  output logic                   wb_valid,
  output logic                   wb_we,
  output la32_pkg::reg_addr_t    wb_rd,
  output la32_pkg::word_t        wb_data,
  output logic                   wb_exc,
  output la32_pkg::exc_cause_e   wb_cause
);

  import la32_pkg::*;

  word_t rf_q [0:`LA32_NREG-1];

  // r0 is hardwired
  assign rf_rj_data = (rf_rj_addr == '0) ? '0 : rf_q[rf_rj_addr];
  assign rf_rk_data = (rf_rk_addr == '0) ? '0 : rf_q[rf_rk_addr];

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int i = 0; i < `LA32_NREG; i++) begin
        rf_q[i] <= `LA32_RF_RST;
      end
    end else if (ex_we) begin
      rf_q[ex_rd] <= ex_data;
    end
  end

  // ##########################################################
  // retire port
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      wb_valid <= 1'b0;
      wb_we    <= 1'b0;
      wb_exc   <= 1'b0;
    end else begin
      wb_valid <= ex_valid;
      wb_we    <= ex_we;
      wb_exc   <= ex_exc;
    end
  end

  always_ff @(posedge clk) begin
    wb_rd    <= ex_rd;
    wb_data  <= ex_data;
    wb_cause <= ex_cause;
  end

  a_no_r0_write: assert property (@(posedge clk) disable iff (!rst_n) wb_we |-> wb_rd != '0)
    else $error("retired write to r0");

endmodule

// ==== source/la32_alu_core.sv ====
`timescale 1ns/1ns

module la32_alu_core (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   inst_valid,
  input  la32_pkg::word_t        inst,
  output logic                   wb_valid,
  output logic                   wb_we,
  output la32_pkg::reg_addr_t    wb_rd,
  output la32_pkg::word_t        wb_data,
  output logic                   wb_exc,
  output la32_pkg::exc_cause_e   wb_cause
);

  import la32_pkg::*;

  // decode to execute
  logic       dec_valid;
  alu_op_e    dec_op;
  reg_addr_t  dec_rj;
  reg_addr_t  dec_rk;
  reg_addr_t  dec_rd;
  logic       dec_use_imm;
  word_t      dec_imm;
  logic       dec_we;
  logic       dec_exc;
  exc_cause_e dec_cause;

  // register file read port
  reg_addr_t  rf_rj_addr;
  reg_addr_t  rf_rk_addr;
  word_t      rf_rj_data;
  word_t      rf_rk_data;

  // execute to writeback
  logic       ex_valid;
  logic       ex_we;
  reg_addr_t  ex_rd;
  word_t      ex_data;
  logic       ex_exc;
  exc_cause_e ex_cause;

  la32_decode u_decode (
    .clk         (clk),
    .rst_n       (rst_n),
    .inst_valid  (inst_valid),
    .inst        (inst),
    .dec_valid   (dec_valid),
    .dec_op      (dec_op),
    .dec_rj      (dec_rj),
    .dec_rk      (dec_rk),
    .dec_rd      (dec_rd),
    .dec_use_imm (dec_use_imm),
    .dec_imm     (dec_imm),
    .dec_we      (dec_we),
    .dec_exc     (dec_exc),
    .dec_cause   (dec_cause)
  );

  la32_execute u_execute (
    .clk         (clk),
    .rst_n       (rst_n),
    .dec_valid   (dec_valid),
    .dec_op      (dec_op),
    .dec_rj      (dec_rj),
    .dec_rk      (dec_rk),
    .dec_rd      (dec_rd),
    .dec_use_imm (dec_use_imm),
    .dec_imm     (dec_imm),
    .dec_we      (dec_we),
    .dec_exc     (dec_exc),
    .dec_cause   (dec_cause),
    .rf_rj_addr  (rf_rj_addr),
    .rf_rk_addr  (rf_rk_addr),
    .rf_rj_data  (rf_rj_data),
    .rf_rk_data  (rf_rk_data),
    .ex_valid    (ex_valid),
    .ex_we       (ex_we),
    .ex_rd       (ex_rd),
    .ex_data     (ex_data),
    .ex_exc      (ex_exc),
    .ex_cause    (ex_cause)
  );

  la32_result u_result (
    .clk         (clk),
    .rst_n       (rst_n),
    .ex_valid    (ex_valid),
    .ex_we       (ex_we),
    .ex_rd       (ex_rd),
    .ex_data     (ex_data),
    .ex_exc      (ex_exc),
    .ex_cause    (ex_cause),
    .rf_rj_addr  (rf_rj_addr),
    .rf_rk_addr  (rf_rk_addr),
    .rf_rj_data  (rf_rj_data),
    .rf_rk_data  (rf_rk_data),
    .wb_valid    (wb_valid),
    .wb_we       (wb_we),
    .wb_rd       (wb_rd),
    .wb_data     (wb_data),
    .wb_exc      (wb_exc),
    .wb_cause    (wb_cause)
  );

endmodule

// ==== tests/la32_ref_model.svh ====
`ifndef LA32_REF_MODEL_SVH
`define LA32_REF_MODEL_SVH

// one expected retirement per cycle, valid low on idle cycles
typedef struct packed {
  logic       valid;
  logic       we;
  reg_addr_t  rd;
  word_t      data;
  logic       exc;
  exc_cause_e cause;
} retire_t;

word_t model_rf [0:`LA32_NREG-1];

// ##########################################################
// instruction encoders
function automatic word_t encode_3r(input logic [16:0] opcode, input reg_addr_t rk,
                                    input reg_addr_t rj, input reg_addr_t rd);
  inst_word_u w;
  w.r3.opcode = opcode;
  w.r3.rk     = rk;
  w.r3.rj     = rj;
  w.r3.rd     = rd;
  return w;
endfunction

function automatic word_t encode_ri12(input logic [9:0] opcode, input logic [11:0] imm12,
                                     input reg_addr_t rj, input reg_addr_t rd);
  inst_word_u w;
  w.ri12.opcode = opcode;
  w.ri12.imm12  = imm12;
  w.ri12.rj     = rj;
  w.ri12.rd     = rd;
  return w;
endfunction

function automatic word_t encode_ri20(input logic [6:0] opcode, input logic [19:0] imm20,
                                     input reg_addr_t rd);
  inst_word_u w;
  w.ri20.opcode = opcode;
  w.ri20.imm20  = imm20;
  w.ri20.rd     = rd;
  return w;
endfunction

// sign bits filled in from the top
function automatic word_t arith_right(input word_t a, input logic [4:0] s);
  return (a >> s) | (~(32'hffffffff >> s) & {32{a[31]}});
endfunction

// ##########################################################
// expected retirement, updates the model register file
function automatic retire_t predict(input word_t w);
  inst_word_u iw;
  retire_t    r;
  word_t      a;
  word_t      b;
  word_t      simm;
  word_t      uimm;
  logic       known;
  iw    = w;
  a     = model_rf[iw.r3.rj];
  b     = model_rf[iw.r3.rk];
  simm  = {{20{iw.ri12.imm12[11]}}, iw.ri12.imm12};
  uimm  = {20'b0, iw.ri12.imm12};
  r     = '0;
  r.valid = 1'b1;
  r.rd    = iw.r3.rd;
  r.cause = exc_none;
  known   = 1'b1;
  case (iw.r3.opcode)
    `LA32_OP_ADDW:    r.data = a + b;
    `LA32_OP_SUBW:    r.data = a - b;
    `LA32_OP_SLT:     r.data = {31'b0, $signed(a) < $signed(b)};
    `LA32_OP_SLTU:    r.data = {31'b0, a < b};
    `LA32_OP_NOR:     r.data = ~(a | b);
    `LA32_OP_AND:     r.data = a & b;
    `LA32_OP_OR:      r.data = a | b;
    `LA32_OP_XOR:     r.data = a ^ b;
    `LA32_OP_SLLW:    r.data = a << b[4:0];
    `LA32_OP_SRLW:    r.data = a >> b[4:0];
    `LA32_OP_SRAW:    r.data = arith_right(a, b[4:0]);
    `LA32_OP_SLLIW:   r.data = a << iw.r3.rk;
    `LA32_OP_SRLIW:   r.data = a >> iw.r3.rk;
    `LA32_OP_SRAIW:   r.data = arith_right(a, iw.r3.rk);
    `LA32_OP_BREAK:   r.cause = exc_brk;
    `LA32_OP_SYSCALL: r.cause = exc_sys;
    default:          known = 1'b0;
  endcase
  if (!known) begin
    known = 1'b1;
    case (iw.ri12.opcode)
      `LA32_OP_SLTI:  r.data = {31'b0, $signed(a) < $signed(simm)};
      `LA32_OP_SLTUI: r.data = {31'b0, a < simm};
      `LA32_OP_ADDIW: r.data = a + simm;
      `LA32_OP_ANDI:  r.data = a & uimm;
      `LA32_OP_ORI:   r.data = a | uimm;
      `LA32_OP_XORI:  r.data = a ^ uimm;
      default:        known = iw.ri20.opcode == `LA32_OP_LU12I;
    endcase
    if (known && iw.ri20.opcode == `LA32_OP_LU12I) begin
      r.data = {iw.ri20.imm20, 12'b0};
    end
  end
  if (!known && w != '0) begin
    r.cause = exc_ine;
  end
  r.exc = (r.cause != exc_none);
  r.we  = known && !r.exc && (r.rd != '0);
  if (r.we) begin
    model_rf[r.rd] = r.data;
  end
  return r;
endfunction

`endif

// ==== tests/tb_la32_alu_core.sv ====
`timescale 1ns/1ns
`include "la32_cfg.svh"

module tb_la32_alu_core;

  import la32_pkg::*;

  `include "la32_ref_model.svh"

  localparam int NUM_WORDS     = 3000;
  localparam int RST_TIMEOUT   = 50;
  localparam int DRAIN_TIMEOUT = 20;

  logic       clk;
  logic       rst_n;
  logic       inst_valid;
  word_t      inst;
  logic       wb_valid;
  logic       wb_we;
  reg_addr_t  wb_rd;
  word_t      wb_data;
  logic       wb_exc;
  exc_cause_e wb_cause;

  integer     seed;
  retire_t    expect_q [$];
  int         in_flight;
  int         retired;

  la32_alu_core u_la32_alu_core (
    .clk        (clk),
    .rst_n      (rst_n),
    .inst_valid (inst_valid),
    .inst       (inst),
    .wb_valid   (wb_valid),
    .wb_we      (wb_we),
    .wb_rd      (wb_rd),
    .wb_data    (wb_data),
    .wb_exc     (wb_exc),
    .wb_cause   (wb_cause)
  );

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  initial begin
    rst_n = 1'b0;
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
  end

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH at %0t ns: %s is %h, expected %h", $time, what, got, exp);
      $display("*** TEST FAILED ***");
      $fatal(1, "stopped at first mismatch");
    end
  endtask

  task automatic fail_timeout(input string what);
    $display("timeout while waiting for %s at %0t ns", what, $time);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped on timeout");
  endtask

  // ##########################################################
  // stimulus
  // mostly low registers so neighbouring words depend on each other
  function automatic reg_addr_t pick_reg();
    if (($random(seed) & 3) != 0) begin
      return reg_addr_t'($random(seed) & 7);
    end
    return reg_addr_t'($random(seed));
  endfunction

  function automatic word_t random_word();
    int          kind;
    int          sel;
    logic [16:0] op17;
    logic [9:0]  op10;
    reg_addr_t   rd;
    reg_addr_t   rj;
    reg_addr_t   rk;
    kind = int'($unsigned($random(seed)) % 16);
    sel  = int'($unsigned($random(seed)) % 14);
    rd   = pick_reg();
    rj   = pick_reg();
    rk   = pick_reg();
    if (kind < 7) begin
      case (sel)
        0:       op17 = `LA32_OP_ADDW;
        1:       op17 = `LA32_OP_SUBW;
        2:       op17 = `LA32_OP_SLT;
        3:       op17 = `LA32_OP_SLTU;
        4:       op17 = `LA32_OP_NOR;
        5:       op17 = `LA32_OP_AND;
        6:       op17 = `LA32_OP_OR;
        7:       op17 = `LA32_OP_XOR;
        8:       op17 = `LA32_OP_SLLW;
        9:       op17 = `LA32_OP_SRLW;
        10:      op17 = `LA32_OP_SRAW;
        11:      op17 = `LA32_OP_SLLIW;
        12:      op17 = `LA32_OP_SRLIW;
        default: op17 = `LA32_OP_SRAIW;
      endcase
      return encode_3r(op17, rk, rj, rd);
    end else if (kind < 11) begin
      case (sel % 6)
        0:       op10 = `LA32_OP_SLTI;
        1:       op10 = `LA32_OP_SLTUI;
        2:       op10 = `LA32_OP_ADDIW;
        3:       op10 = `LA32_OP_ANDI;
        4:       op10 = `LA32_OP_ORI;
        default: op10 = `LA32_OP_XORI;
      endcase
      return encode_ri12(op10, 12'($random(seed)), rj, rd);
    end else if (kind == 11) begin
      return encode_ri20(`LA32_OP_LU12I, 20'($random(seed)), rd);
    end else if (kind == 12) begin
      op17 = sel[0] ? `LA32_OP_BREAK : `LA32_OP_SYSCALL;
      return encode_3r(op17, rk, rj, rd);
    end else if (kind == 13) begin
      return '0;
    end
    // mostly illegal, the model decodes it either way
    return $random(seed);
  endfunction

  task automatic drive_word(input logic valid, input word_t w);
    retire_t e;
    inst_valid = valid;
    inst       = w;
    e          = '0;
    if (valid) begin
      e = predict(w);
      in_flight++;
    end
    expect_q.push_back(e);
  endtask

  // outputs of the word driven three falling edges ago
  task automatic check_retire();
    retire_t e;
    e = expect_q.pop_front();
    check_value("wb_valid", 32'(wb_valid), 32'(e.valid));
    if (e.valid) begin
      in_flight--;
      retired++;
      check_value("wb_we", 32'(wb_we), 32'(e.we));
      check_value("wb_rd", 32'(wb_rd), 32'(e.rd));
      check_value("wb_exc", 32'(wb_exc), 32'(e.exc));
      check_value("wb_cause", 32'(wb_cause), 32'(e.cause));
      if (e.we) begin
        check_value("wb_data", wb_data, e.data);
      end
    end
  endtask

  // ##########################################################
  // main sequence
  initial begin
    int      wait_cycles;
    int      drain_cycles;
    retire_t idle;
    seed       = 32'h4f10;
    inst_valid = 1'b0;
    inst       = '0;
    in_flight  = 0;
    retired    = 0;
    idle       = '0;
    for (int i = 0; i < `LA32_NREG; i++) begin
      model_rf[i] = '0;
    end
    // pipeline is empty for the first three checks
    for (int i = 0; i < 3; i++) begin
      expect_q.push_back(idle);
    end

    wait_cycles = 0;
    while (rst_n !== 1'b1) begin
      @(posedge clk);
      wait_cycles++;
      if (wait_cycles > RST_TIMEOUT) begin
        fail_timeout("reset release");
      end
    end

    for (int n = 0; n < NUM_WORDS; n++) begin
      @(negedge clk);
      check_retire();
      if (($random(seed) & 7) != 0) begin
        drive_word(1'b1, random_word());
      end else begin
        drive_word(1'b0, $random(seed));
      end
    end

    drain_cycles = 0;
    while (in_flight > 0) begin
      @(negedge clk);
      check_retire();
      drive_word(1'b0, '0);
      drain_cycles++;
      if (drain_cycles > DRAIN_TIMEOUT) begin
        fail_timeout("the last retirements");
      end
    end

    $display("retired %0d instructions", retired);
    $display("*** TEST PASSED ***");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+source
+incdir+tests
source/la32_pkg.sv
source/la32_decode.sv
source/la32_execute.sv
source/la32_result.sv
source/la32_alu_core.sv
tests/tb_la32_alu_core.sv

// ==== run.sh ====
#!/bin/sh
# build and run the la32 testbench with Verilator

cd "$(dirname "$0")" &&
verilator --binary --assert -Wno-fatal --top-module tb_la32_alu_core \
  -f vlog.f -o tb_sim || { echo "build failed"; exit 1; }

out="$(./obj_dir/tb_sim 2>&1)"
printf '%s\n' "$out"
printf '%s\n' "$out" | grep -qF '*** TEST PASSED ***' &&
  echo "simulation: pass" || { echo "simulation: fail"; exit 1; }
